// File: list.f
+incdir+.
tl_pkg.sv
tl_route_pkg.sv
tl_socket_m1.sv
tl_socket_1n.sv
tl_ram_device.sv
tl_wrapper.sv
tb_tl_wrapper.sv

// File: tb_tl_wrapper.sv
/* Testbench for the TL-UL interconnect top level
   Random host drivers, external device model and response scoreboard */
`timescale 1ns/100ps
`default_nettype none
`include "tl_macros.svh"

module tb_tl_wrapper
  import tl_pkg::*;
  import tl_route_pkg::*;
();

  localparam int N       = `TL_NUM_HOSTS;
  localparam int NSRC    = 1 << `TL_HSW;
  localparam int REQS    = 200;
  localparam int PREFILL = `TL_RAM_WORDS;
  localparam int LIMIT   = 400 * 20;

  logic                clk_i;
  logic                reset_i;
  logic [N-1:0]        host_a_valid_i;
  tl_a_op_e            host_a_opcode_i  [N];
  logic [`TL_AW-1:0]   host_a_address_i [N];
  logic [`TL_DW-1:0]   host_a_data_i    [N];
  logic [`TL_DW/8-1:0] host_a_mask_i    [N];
  logic [`TL_HSW-1:0]  host_a_source_i  [N];
  logic [N-1:0]        host_a_ready_o;
  logic [N-1:0]        host_d_valid_o;
  tl_d_op_e            host_d_opcode_o  [N];
  logic [`TL_DW-1:0]   host_d_data_o    [N];
  logic [`TL_HSW-1:0]  host_d_source_o  [N];
  logic [N-1:0]        host_d_denied_o;
  logic [N-1:0]        host_d_ready_i;
  logic                dev_a_valid_o;
  tl_a_op_e            dev_a_opcode_o;
  logic [`TL_AW-1:0]   dev_a_address_o;
  logic [`TL_DW-1:0]   dev_a_data_o;
  logic [`TL_DW/8-1:0] dev_a_mask_o;
  logic [`TL_DSW-1:0]  dev_a_source_o;
  logic                dev_a_ready_i;
  logic                dev_d_valid_i;
  tl_d_op_e            dev_d_opcode_i;
  logic [`TL_DW-1:0]   dev_d_data_i;
  logic [`TL_DSW-1:0]  dev_d_source_i;
  logic                dev_d_denied_i;
  logic                dev_d_ready_o;

  integer seed = 37;
  int     cyc = 0;
  int     rsp_cnt = 0;
  int     issued [N];
  int     xfers  [N];

  // Expected response per host and source, set when A transfers
  logic              busy     [N][NSRC];
  tl_d_op_e          exp_op   [N][NSRC];
  logic [`TL_DW-1:0] exp_data [N][NSRC];
  logic              exp_den  [N][NSRC];

  // Reference memories for both devices
  logic [`TL_DW-1:0] ref_ram [`TL_RAM_WORDS];
  logic [`TL_DW-1:0] ref_ext [logic [`TL_AW-1:0]];

  // External device storage and its in-order response queue
  logic [`TL_DW-1:0]  ext_mem [logic [`TL_AW-1:0]];
  logic [`TL_DSW-1:0] q_src  [$];
  tl_d_op_e           q_op   [$];
  logic [`TL_DW-1:0]  q_data [$];
  int                 q_due  [$];

  tl_wrapper DUT (.*);

  always #4 clk_i = ~clk_i;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_opcode(input tl_d_op_e got, input tl_d_op_e exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s opcode %s, expected %s",
                         $time, what, got.name(), exp.name()));
    end
  endtask

  task automatic check_data(input logic [`TL_DW-1:0] got, input logic [`TL_DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s data %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_source(input logic [`TL_HSW-1:0] got, input logic [`TL_HSW-1:0] exp,
                              input string what);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s source %0d, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_denied(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s denied %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic logic [`TL_DW-1:0] merge_bytes(input logic [`TL_DW-1:0] old,
                                                    input logic [`TL_DW-1:0] wdata,
                                                    input logic [`TL_DW/8-1:0] mask);
    logic [`TL_DW-1:0] res;
    res = old;
    for (int b = 0; b < `TL_DW/8; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Unwritten external words read back as a pattern of the address
  function automatic logic [`TL_DW-1:0] fill_word(input logic [`TL_AW-1:0] addr);
    return addr ^ 32'hC3A5_5A3C;
  endfunction

  task automatic record_request(input int h);
    logic [`TL_AW-1:0] addr;
    logic [`TL_DW-1:0] old;
    logic [`TL_HSW-1:0] s;
    int word;
    addr = host_a_address_i[h];
    s = host_a_source_i[h];
    exp_op[h][s] = (host_a_opcode_i[h] == Get) ? AccessAckData : AccessAck;
    exp_data[h][s] = '0;
    exp_den[h][s] = 1'b0;
    if (addr >= `TL_DEV1_BASE && addr <= (`TL_DEV1_BASE | `TL_DEV1_MASK)) begin
      word = int'((addr - `TL_DEV1_BASE) >> 2);
      // Beyond the RAM depth nothing is written
      if (word >= `TL_RAM_WORDS) begin
        exp_den[h][s] = 1'b1;
      end else if (host_a_opcode_i[h] == Get) begin
        exp_data[h][s] = ref_ram[word];
      end else begin
        ref_ram[word] = merge_bytes(ref_ram[word], host_a_data_i[h], host_a_mask_i[h]);
      end
    end else begin
      old = ref_ext.exists(addr) ? ref_ext[addr] : fill_word(addr);
      if (host_a_opcode_i[h] == Get) begin
        exp_data[h][s] = old;
      end else begin
        ref_ext[addr] = merge_bytes(old, host_a_data_i[h], host_a_mask_i[h]);
      end
    end
    busy[h][s] = 1'b1;
    xfers[h]++;
  endtask

  task automatic accept_ext_request();
    host_idx_t tag;
    logic [`TL_DW-1:0] old;
    tag = dev_a_source_o[`TL_DSW-1:`TL_HSW];
    if (!(host_a_valid_i[tag] && host_a_ready_o[tag])) begin
      stop_run("External device saw an A beat tagged for a host that sent nothing");
    end
    check_source(dev_a_source_o[`TL_HSW-1:0], host_a_source_i[tag], "external A");
    old = ext_mem.exists(dev_a_address_o) ? ext_mem[dev_a_address_o] : fill_word(dev_a_address_o);
    if (dev_a_opcode_o == Get) begin
      q_op.push_back(AccessAckData);
      q_data.push_back(old);
    end else begin
      ext_mem[dev_a_address_o] = merge_bytes(old, dev_a_data_o, dev_a_mask_o);
      q_op.push_back(AccessAck);
      q_data.push_back('0);
    end
    q_src.push_back(dev_a_source_o);
    q_due.push_back(cyc + {$random(seed)} % 4);
  endtask

  task automatic drive_ext_response();
    if (dev_d_valid_i && dev_d_ready_o) begin
      q_src.delete(0);
      q_op.delete(0);
      q_data.delete(0);
      q_due.delete(0);
    end
    // A stalled response holds its payload
    if (!(dev_d_valid_i && !dev_d_ready_o)) begin
      if (q_src.size() > 0 && q_due[0] <= cyc) begin
        dev_d_valid_i  <= 1'b1;
        dev_d_opcode_i <= q_op[0];
        dev_d_data_i   <= q_data[0];
        dev_d_source_i <= q_src[0];
        dev_d_denied_i <= 1'b0;
      end else begin
        dev_d_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic check_response(input int h);
    logic [`TL_HSW-1:0] s;
    string what;
    s = host_d_source_o[h];
    if (!busy[h][s]) begin
      stop_run($sformatf("Host %0d got a response for source %0d with no request outstanding",
                         h, s));
    end
    what = $sformatf("host %0d source %0d", h, s);
    check_opcode(host_d_opcode_o[h], exp_op[h][s], what);
    check_data(host_d_data_o[h], exp_data[h][s], what);
    check_denied(host_d_denied_o[h], exp_den[h][s], what);
    busy[h][s] = 1'b0;
    rsp_cnt++;
  endtask

  task automatic drive_host(input int h);
    logic [`TL_AW-1:0] addr;
    logic [`TL_HSW-1:0] s;
    logic start;
    logic found;
    int off;
    int word;
    if (!host_a_valid_i[h] || host_a_ready_o[h]) begin
      start = issued[h] < REQS && ({$random(seed)} % 4) != 0;
      // Second host waits until every RAM word holds known data
      if (h != 0 && xfers[0] < PREFILL) begin
        start = 1'b0;
      end
      found = 1'b0;
      s = '0;
      off = {$random(seed)} % NSRC;
      for (int k = 0; k < NSRC; k++) begin
        if (!found && !busy[h][(off + k) % NSRC]) begin
          s = (off + k) % NSRC;
          found = 1'b1;
        end
      end
      if (start && found) begin
        word = {$random(seed)} % 16;
        if (h == 0 && issued[0] < PREFILL) begin
          host_a_opcode_i[h] <= PutFullData;
          host_a_mask_i[h]   <= '1;
          addr = `TL_DEV1_BASE + 4 * issued[0];
        end else begin
          host_a_opcode_i[h] <= (({$random(seed)} % 2) != 0) ? Get : PutFullData;
          host_a_mask_i[h]   <= $random(seed);
          case ({$random(seed)} % 3)
            0: addr = 32'h2000_0000 + 4 * word;
            1: addr = `TL_DEV1_BASE + 4 * word;
            default: addr = `TL_DEV1_BASE + 4 * (`TL_RAM_WORDS + word);
          endcase
        end
        host_a_valid_i[h]   <= 1'b1;
        host_a_address_i[h] <= addr;
        host_a_data_i[h]    <= $random(seed);
        host_a_source_i[h]  <= s;
        issued[h]++;
      end else begin
        host_a_valid_i[h] <= 1'b0;
      end
    end
    host_d_ready_i[h] <= ({$random(seed)} % 4) != 0;
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    host_a_valid_i = '0;
    host_d_ready_i = '0;
    for (int h = 0; h < N; h++) begin
      host_a_opcode_i[h]  = Get;
      host_a_address_i[h] = '0;
      host_a_data_i[h]    = '0;
      host_a_mask_i[h]    = '0;
      host_a_source_i[h]  = '0;
      issued[h] = 0;
      xfers[h]  = 0;
      for (int s = 0; s < NSRC; s++) begin
        busy[h][s] = 1'b0;
      end
    end
    dev_a_ready_i  = 1'b0;
    dev_d_valid_i  = 1'b0;
    dev_d_opcode_i = AccessAck;
    dev_d_data_i   = '0;
    dev_d_source_i = '0;
    dev_d_denied_i = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      cyc++;
      if (cyc > LIMIT) begin
        stop_run("Timeout, the requests did not all complete within the cycle limit");
      end
      for (int h = 0; h < N; h++) begin
        if (host_a_valid_i[h] && host_a_ready_o[h]) begin
          record_request(h);
        end
      end
      if (dev_a_valid_o && dev_a_ready_i) begin
        accept_ext_request();
      end
      for (int h = 0; h < N; h++) begin
        if (host_d_valid_o[h] && host_d_ready_i[h]) begin
          check_response(h);
        end
        drive_host(h);
      end
      drive_ext_response();
      dev_a_ready_i <= ({$random(seed)} % 3) != 0;
      if (rsp_cnt == N * REQS) begin
        $display("No errors");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// File: tl_wrapper.sv
/* TL-UL interconnect top level
   Hosts to socket_m1, socket_1n, RAM device and external device port */
`timescale 1ns/100ps
`default_nettype none
`include "tl_macros.svh"

module tl_wrapper
  import tl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic [`TL_NUM_HOSTS-1:0] host_a_valid_i,
  input  tl_a_op_e                 host_a_opcode_i  [`TL_NUM_HOSTS],
  input  logic [`TL_AW-1:0]        host_a_address_i [`TL_NUM_HOSTS],
  input  logic [`TL_DW-1:0]        host_a_data_i    [`TL_NUM_HOSTS],
  input  logic [`TL_DW/8-1:0]      host_a_mask_i    [`TL_NUM_HOSTS],
  input  logic [`TL_HSW-1:0]       host_a_source_i  [`TL_NUM_HOSTS],
  output logic [`TL_NUM_HOSTS-1:0] host_a_ready_o,
  output logic [`TL_NUM_HOSTS-1:0] host_d_valid_o,
  output tl_d_op_e                 host_d_opcode_o  [`TL_NUM_HOSTS],
  output logic [`TL_DW-1:0]        host_d_data_o    [`TL_NUM_HOSTS],
  output logic [`TL_HSW-1:0]       host_d_source_o  [`TL_NUM_HOSTS],
  output logic [`TL_NUM_HOSTS-1:0] host_d_denied_o,
  input  logic [`TL_NUM_HOSTS-1:0] host_d_ready_i,

  output logic                     dev_a_valid_o,
  output tl_a_op_e                 dev_a_opcode_o,
  output logic [`TL_AW-1:0]        dev_a_address_o,
  output logic [`TL_DW-1:0]        dev_a_data_o,
  output logic [`TL_DW/8-1:0]      dev_a_mask_o,
  output logic [`TL_DSW-1:0]       dev_a_source_o,
  input  logic                     dev_a_ready_i,
  input  logic                     dev_d_valid_i,
  input  tl_d_op_e                 dev_d_opcode_i,
  input  logic [`TL_DW-1:0]        dev_d_data_i,
  input  logic [`TL_DSW-1:0]       dev_d_source_i,
  input  logic                     dev_d_denied_i,
  output logic                     dev_d_ready_o
);

  // Link between the two sockets
  logic                xbar_a_valid;
  tl_a_op_e            xbar_a_opcode;
  logic [`TL_AW-1:0]   xbar_a_address;
  logic [`TL_DW-1:0]   xbar_a_data;
  logic [`TL_DW/8-1:0] xbar_a_mask;
  logic [`TL_DSW-1:0]  xbar_a_source;
  logic                xbar_a_ready;
  logic                xbar_d_valid;
  tl_d_op_e            xbar_d_opcode;
  logic [`TL_DW-1:0]   xbar_d_data;
  logic [`TL_DSW-1:0]  xbar_d_source;
  logic                xbar_d_denied;
  logic                xbar_d_ready;

  // RAM link
  logic                ram_a_valid;
  tl_a_op_e            ram_a_opcode;
  logic [`TL_AW-1:0]   ram_a_address;
  logic [`TL_DW-1:0]   ram_a_data;
  logic [`TL_DW/8-1:0] ram_a_mask;
  logic [`TL_DSW-1:0]  ram_a_source;
  logic                ram_a_ready;
  logic                ram_d_valid;
  tl_d_op_e            ram_d_opcode;
  logic [`TL_DW-1:0]   ram_d_data;
  logic [`TL_DSW-1:0]  ram_d_source;
  logic                ram_d_denied;
  logic                ram_d_ready;

  tl_socket_m1 socket_m1 (
    .clk_i,
    .reset_i,
    .host_a_valid_i,
    .host_a_opcode_i,
    .host_a_address_i,
    .host_a_data_i,
    .host_a_mask_i,
    .host_a_source_i,
    .host_a_ready_o,
    .host_d_valid_o,
    .host_d_opcode_o,
    .host_d_data_o,
    .host_d_source_o,
    .host_d_denied_o,
    .host_d_ready_i,
    .dev_a_valid_o   (xbar_a_valid),
    .dev_a_opcode_o  (xbar_a_opcode),
    .dev_a_address_o (xbar_a_address),
    .dev_a_data_o    (xbar_a_data),
    .dev_a_mask_o    (xbar_a_mask),
    .dev_a_source_o  (xbar_a_source),
    .dev_a_ready_i   (xbar_a_ready),
    .dev_d_valid_i   (xbar_d_valid),
    .dev_d_opcode_i  (xbar_d_opcode),
    .dev_d_data_i    (xbar_d_data),
    .dev_d_source_i  (xbar_d_source),
    .dev_d_denied_i  (xbar_d_denied),
    .dev_d_ready_o   (xbar_d_ready)
  );

  tl_socket_1n socket_1n (
    .clk_i,
    .reset_i,
    .host_a_valid_i   (xbar_a_valid),
    .host_a_opcode_i  (xbar_a_opcode),
    .host_a_address_i (xbar_a_address),
    .host_a_data_i    (xbar_a_data),
    .host_a_mask_i    (xbar_a_mask),
    .host_a_source_i  (xbar_a_source),
    .host_a_ready_o   (xbar_a_ready),
    .host_d_valid_o   (xbar_d_valid),
    .host_d_opcode_o  (xbar_d_opcode),
    .host_d_data_o    (xbar_d_data),
    .host_d_source_o  (xbar_d_source),
    .host_d_denied_o  (xbar_d_denied),
    .host_d_ready_i   (xbar_d_ready),
    .ext_a_valid_o    (dev_a_valid_o),
    .ext_a_opcode_o   (dev_a_opcode_o),
    .ext_a_address_o  (dev_a_address_o),
    .ext_a_data_o     (dev_a_data_o),
    .ext_a_mask_o     (dev_a_mask_o),
    .ext_a_source_o   (dev_a_source_o),
    .ext_a_ready_i    (dev_a_ready_i),
    .ext_d_valid_i    (dev_d_valid_i),
    .ext_d_opcode_i   (dev_d_opcode_i),
    .ext_d_data_i     (dev_d_data_i),
    .ext_d_source_i   (dev_d_source_i),
    .ext_d_denied_i   (dev_d_denied_i),
    .ext_d_ready_o    (dev_d_ready_o),
    .ram_a_valid_o    (ram_a_valid),
    .ram_a_opcode_o   (ram_a_opcode),
    .ram_a_address_o  (ram_a_address),
    .ram_a_data_o     (ram_a_data),
    .ram_a_mask_o     (ram_a_mask),
    .ram_a_source_o   (ram_a_source),
    .ram_a_ready_i    (ram_a_ready),
    .ram_d_valid_i    (ram_d_valid),
    .ram_d_opcode_i   (ram_d_opcode),
    .ram_d_data_i     (ram_d_data),
    .ram_d_source_i   (ram_d_source),
    .ram_d_denied_i   (ram_d_denied),
    .ram_d_ready_o    (ram_d_ready)
  );

  tl_ram_device ram_device (
    .clk_i,
    .reset_i,
    .a_valid_i   (ram_a_valid),
    .a_ready_o   (ram_a_ready),
    .a_opcode_i  (ram_a_opcode),
    .a_address_i (ram_a_address),
    .a_data_i    (ram_a_data),
    .a_mask_i    (ram_a_mask),
    .a_source_i  (ram_a_source),
    .d_valid_o   (ram_d_valid),
    .d_ready_i   (ram_d_ready),
    .d_opcode_o  (ram_d_opcode),
    .d_data_o    (ram_d_data),
    .d_source_o  (ram_d_source),
    .d_denied_o  (ram_d_denied)
  );

endmodule

`default_nettype wire

// File: tl_ram_device.sv
/* Single-beat TL-UL RAM device
   Get and PutFullData, denied response beyond the RAM depth */
`timescale 1ns/100ps
`default_nettype none
`include "tl_macros.svh"

module tl_ram_device
  import tl_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  tl_a_op_e            a_opcode_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  input  logic [`TL_DW/8-1:0] a_mask_i,
  input  logic [`TL_DSW-1:0]  a_source_i,
  output logic                d_valid_o,
  input  logic                d_ready_i,
  output tl_d_op_e            d_opcode_o,
  output logic [`TL_DW-1:0]   d_data_o,
  output logic [`TL_DSW-1:0]  d_source_o,
  output logic                d_denied_o
);

  localparam int IdxW = $clog2(`TL_RAM_WORDS);

  logic [`TL_DW-1:0] mem [`TL_RAM_WORDS];
  logic [`TL_AW-1:0] local_addr;
  logic [IdxW-1:0]   word_idx;
  logic              in_range;
  logic              a_xfer;
  logic              d_valid_q;

  assign local_addr = a_address_i & `TL_DEV1_MASK;
  assign word_idx   = local_addr[IdxW+1:2];
  assign in_range   = local_addr[`TL_AW-1:2] < `TL_RAM_WORDS;

  // One response in flight at a time
  assign a_ready_o = !d_valid_q;
  assign a_xfer    = a_valid_i && a_ready_o;
  assign d_valid_o = d_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      d_valid_q <= 1'b0;
    end else if (a_xfer) begin
      d_valid_q <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_q <= 1'b0;
    end
  end

  // Byte-masked write, only inside the RAM depth
  always_ff @(posedge clk_i) begin
    if (a_xfer && a_opcode_i == PutFullData && in_range) begin
      for (int b = 0; b < `TL_DW/8; b++) begin
        if (a_mask_i[b]) begin
          mem[word_idx][8*b +: 8] <= a_data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_xfer) begin
      d_opcode_o <= (a_opcode_i == Get) ? AccessAckData : AccessAck;
      d_data_o   <= (a_opcode_i == Get && in_range) ? mem[word_idx] : '0;
      d_source_o <= a_source_i;
      d_denied_o <= !in_range;
    end
  end

  // Held response is not overwritten by a new A
  hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_source_o) && $stable(d_data_o));

endmodule

`default_nettype wire

// File: tl_socket_1n.sv
/* One-to-many TL-UL socket
   Address decode of A onto the device links, D merge with RAM priority */
`timescale 1ns/100ps
`default_nettype none
`include "tl_macros.svh"

module tl_socket_1n
  import tl_pkg::*;
  import tl_route_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,

  input  logic                host_a_valid_i,
  input  tl_a_op_e            host_a_opcode_i,
  input  logic [`TL_AW-1:0]   host_a_address_i,
  input  logic [`TL_DW-1:0]   host_a_data_i,
  input  logic [`TL_DW/8-1:0] host_a_mask_i,
  input  logic [`TL_DSW-1:0]  host_a_source_i,
  output logic                host_a_ready_o,
  output logic                host_d_valid_o,
  output tl_d_op_e            host_d_opcode_o,
  output logic [`TL_DW-1:0]   host_d_data_o,
  output logic [`TL_DSW-1:0]  host_d_source_o,
  output logic                host_d_denied_o,
  input  logic                host_d_ready_i,

  output logic                ext_a_valid_o,
  output tl_a_op_e            ext_a_opcode_o,
  output logic [`TL_AW-1:0]   ext_a_address_o,
  output logic [`TL_DW-1:0]   ext_a_data_o,
  output logic [`TL_DW/8-1:0] ext_a_mask_o,
  output logic [`TL_DSW-1:0]  ext_a_source_o,
  input  logic                ext_a_ready_i,
  input  logic                ext_d_valid_i,
  input  tl_d_op_e            ext_d_opcode_i,
  input  logic [`TL_DW-1:0]   ext_d_data_i,
  input  logic [`TL_DSW-1:0]  ext_d_source_i,
  input  logic                ext_d_denied_i,
  output logic                ext_d_ready_o,

  output logic                ram_a_valid_o,
  output tl_a_op_e            ram_a_opcode_o,
  output logic [`TL_AW-1:0]   ram_a_address_o,
  output logic [`TL_DW-1:0]   ram_a_data_o,
  output logic [`TL_DW/8-1:0] ram_a_mask_o,
  output logic [`TL_DSW-1:0]  ram_a_source_o,
  input  logic                ram_a_ready_i,
  input  logic                ram_d_valid_i,
  input  tl_d_op_e            ram_d_opcode_i,
  input  logic [`TL_DW-1:0]   ram_d_data_i,
  input  logic [`TL_DSW-1:0]  ram_d_source_i,
  input  logic                ram_d_denied_i,
  output logic                ram_d_ready_o
);

  tl_link_e a_link;

  // RAM window, everything else is the default device
  assign a_link = ((host_a_address_i & ~`TL_DEV1_MASK) == `TL_DEV1_BASE) ?
                  LINK_RAM : LINK_EXT;

  assign ext_a_valid_o   = host_a_valid_i && (a_link == LINK_EXT);
  assign ram_a_valid_o   = host_a_valid_i && (a_link == LINK_RAM);
  assign host_a_ready_o  = (a_link == LINK_RAM) ? ram_a_ready_i : ext_a_ready_i;

  assign ext_a_opcode_o  = host_a_opcode_i;
  assign ext_a_address_o = host_a_address_i;
  assign ext_a_data_o    = host_a_data_i;
  assign ext_a_mask_o    = host_a_mask_i;
  assign ext_a_source_o  = host_a_source_i;
  assign ram_a_opcode_o  = host_a_opcode_i;
  assign ram_a_address_o = host_a_address_i;
  assign ram_a_data_o    = host_a_data_i;
  assign ram_a_mask_o    = host_a_mask_i;
  assign ram_a_source_o  = host_a_source_i;

  // RAM wins the D merge, external device waits
  assign host_d_valid_o  = ram_d_valid_i || ext_d_valid_i;
  assign host_d_opcode_o = ram_d_valid_i ? ram_d_opcode_i : ext_d_opcode_i;
  assign host_d_data_o   = ram_d_valid_i ? ram_d_data_i : ext_d_data_i;
  assign host_d_source_o = ram_d_valid_i ? ram_d_source_i : ext_d_source_i;
  assign host_d_denied_o = ram_d_valid_i ? ram_d_denied_i : ext_d_denied_i;
  assign ram_d_ready_o   = host_d_ready_i;
  assign ext_d_ready_o   = host_d_ready_i && !ram_d_valid_i;

  // Losing external response is stalled and still offered next cycle
  d_merge_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ram_d_valid_i && ext_d_valid_i |-> !ext_d_ready_o ##1 ext_d_valid_i);

endmodule

`default_nettype wire

// File: tl_socket_m1.sv
/* Many-to-one TL-UL socket
   Round-robin A arbitration with grant lock, D returned by source tag */
`timescale 1ns/100ps
`default_nettype none
`include "tl_macros.svh"

module tl_socket_m1
  import tl_pkg::*;
  import tl_route_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic [`TL_NUM_HOSTS-1:0] host_a_valid_i,
  input  tl_a_op_e                 host_a_opcode_i  [`TL_NUM_HOSTS],
  input  logic [`TL_AW-1:0]        host_a_address_i [`TL_NUM_HOSTS],
  input  logic [`TL_DW-1:0]        host_a_data_i    [`TL_NUM_HOSTS],
  input  logic [`TL_DW/8-1:0]      host_a_mask_i    [`TL_NUM_HOSTS],
  input  logic [`TL_HSW-1:0]       host_a_source_i  [`TL_NUM_HOSTS],
  output logic [`TL_NUM_HOSTS-1:0] host_a_ready_o,
  output logic [`TL_NUM_HOSTS-1:0] host_d_valid_o,
  output tl_d_op_e                 host_d_opcode_o  [`TL_NUM_HOSTS],
  output logic [`TL_DW-1:0]        host_d_data_o    [`TL_NUM_HOSTS],
  output logic [`TL_HSW-1:0]       host_d_source_o  [`TL_NUM_HOSTS],
  output logic [`TL_NUM_HOSTS-1:0] host_d_denied_o,
  input  logic [`TL_NUM_HOSTS-1:0] host_d_ready_i,

  output logic                     dev_a_valid_o,
  output tl_a_op_e                 dev_a_opcode_o,
  output logic [`TL_AW-1:0]        dev_a_address_o,
  output logic [`TL_DW-1:0]        dev_a_data_o,
  output logic [`TL_DW/8-1:0]      dev_a_mask_o,
  output logic [`TL_DSW-1:0]       dev_a_source_o,
  input  logic                     dev_a_ready_i,
  input  logic                     dev_d_valid_i,
  input  tl_d_op_e                 dev_d_opcode_i,
  input  logic [`TL_DW-1:0]        dev_d_data_i,
  input  logic [`TL_DSW-1:0]       dev_d_source_i,
  input  logic                     dev_d_denied_i,
  output logic                     dev_d_ready_o
);

  localparam int N = `TL_NUM_HOSTS;

  logic [N-1:0] gnt_rr;
  logic [N-1:0] gnt_q;
  logic [N-1:0] gnt;
  logic         lock_q;
  host_idx_t    ptr_q;
  host_idx_t    sel_idx;
  host_idx_t    d_host;
  logic         a_xfer;

  // Round robin, first valid host at or after the pointer
  always_comb begin
    int idx;
    gnt_rr = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(ptr_q) + k) % N;
      if (gnt_rr == '0 && host_a_valid_i[idx]) begin
        gnt_rr[idx] = 1'b1;
      end
    end
  end

  assign gnt = lock_q ? gnt_q : gnt_rr;

  always_comb begin
    sel_idx = '0;
    for (int k = 0; k < N; k++) begin
      if (gnt[k]) begin
        sel_idx = host_idx_t'(k);
      end
    end
  end

  assign dev_a_valid_o   = |(gnt & host_a_valid_i);
  assign dev_a_opcode_o  = host_a_opcode_i[sel_idx];
  assign dev_a_address_o = host_a_address_i[sel_idx];
  assign dev_a_data_o    = host_a_data_i[sel_idx];
  assign dev_a_mask_o    = host_a_mask_i[sel_idx];
  assign dev_a_source_o  = {sel_idx, host_a_source_i[sel_idx]};
  assign host_a_ready_o  = gnt & {N{dev_a_ready_i}};
  assign a_xfer          = dev_a_valid_o && dev_a_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      ptr_q  <= '0;
    end else begin
      // Stalled beat keeps its grant
      lock_q <= dev_a_valid_o && !dev_a_ready_i;
      if (a_xfer) begin
        ptr_q <= (sel_idx == host_idx_t'(N-1)) ? '0 : sel_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!lock_q) begin
      gnt_q <= gnt_rr;
    end
  end

  // D goes back to the host named by the source tag
  assign d_host = dev_d_source_i[`TL_DSW-1:`TL_HSW];

  always_comb begin
    for (int i = 0; i < N; i++) begin
      host_d_valid_o[i]  = dev_d_valid_i && (d_host == host_idx_t'(i));
      host_d_opcode_o[i] = dev_d_opcode_i;
      host_d_data_o[i]   = dev_d_data_i;
      host_d_source_o[i] = dev_d_source_i[`TL_HSW-1:0];
      host_d_denied_o[i] = dev_d_denied_i;
    end
  end

  assign dev_d_ready_o = host_d_ready_i[d_host];

  gnt_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(gnt));

  gnt_lock_a: assert property (@(posedge clk_i) disable iff (reset_i)
    dev_a_valid_o && !dev_a_ready_i |=> gnt == $past(gnt));

endmodule

`default_nettype wire

// File: tl_route_pkg.sv
/* Routing types for the sockets
   Device link select and host index */
`default_nettype none
`include "tl_macros.svh"

package tl_route_pkg;

  typedef enum logic {
    LINK_EXT = 1'b0,
    LINK_RAM = 1'b1
  } tl_link_e;

  // Also the top bit(s) of the device-side source
  typedef logic [$clog2(`TL_NUM_HOSTS)-1:0] host_idx_t;

endpackage

`default_nettype wire

// File: tl_pkg.sv
/* TL-UL protocol types
   A and D channel opcode enums */
`default_nettype none

package tl_pkg;

  // Channel A opcodes, TL-UL subset
  typedef enum logic [2:0] {
    PutFullData = 3'd0,
    Get         = 3'd4
  } tl_a_op_e;

  // Channel D opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

endpackage

`default_nettype wire

// File: tl_macros.svh
/* Widths, host count, address map and RAM depth
   shared by the TL-UL interconnect */
`ifndef TL_MACROS_SVH
`define TL_MACROS_SVH

// Bus widths, mask is TL_DW/8 bits
`define TL_AW 32
`define TL_DW 32

// Source widths, device side carries the host index on top
`define TL_HSW 2
`define TL_DSW (`TL_HSW + 1)

`define TL_NUM_HOSTS 2

// RAM window, everything else falls through to device 0
`define TL_DEV1_BASE 32'h1000_0000
`define TL_DEV1_MASK 32'h0FFF_FFFF
`define TL_RAM_WORDS 16

`endif
